// File: build.f
+incdir+verilog
verilog/cart_pkg.sv
verilog/mapper_config.sv
verilog/address_map.sv
verilog/select_filter.sv
verilog/cart_decoder_top.sv
tests/tb_cart_decoder.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cart decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cart_decoder -f build.f -o sim_cart_decoder
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_cart_decoder)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Test passed$"; then
  exit 0
fi
echo "Pass message not found"
exit 1

// File: tests/tb_cart_decoder.sv
`timescale 1ns/1ps

module tb_cart_decoder;
  import cart_pkg::*;

  logic        CLK;
  logic        rst_n;
  logic        cfg_we;
  cfg_reg_t    cfg_sel;
  logic [23:0] cfg_data;
  logic [23:0] snes_addr;
  logic [23:0] mcu_addr;
  logic        bus_phase;
  logic [23:0] mem_addr;
  logic        is_rom;
  logic        is_saveram;
  logic        is_writable;
  logic        use_bsx;
  logic        msu_enable;
  logic        dspx_enable;
  logic        dspx_a0;
  logic        srtc_enable;

  // Copy of what the testbench has written to the config file
  mapper_t     sh_mapper;
  logic [7:0]  sh_feat;
  logic [23:0] sh_rom;
  logic [23:0] sh_sram;
  logic [14:0] sh_bsx;

  integer      seed;
  integer      fail_count;
  logic [26:0] exp_map;            // {writable, saveram, rom, addr}
  logic        exp_msu;
  logic        exp_dspx;
  logic        exp_a0;
  logic        exp_srtc;

  cart_decoder_top UUT (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .cfg_we      (cfg_we),
    .cfg_sel     (cfg_sel),
    .cfg_data    (cfg_data),
    .snes_addr   (snes_addr),
    .mcu_addr    (mcu_addr),
    .bus_phase   (bus_phase),
    .mem_addr    (mem_addr),
    .is_rom      (is_rom),
    .is_saveram  (is_saveram),
    .is_writable (is_writable),
    .use_bsx     (use_bsx),
    .msu_enable  (msu_enable),
    .dspx_enable (dspx_enable),
    .dspx_a0     (dspx_a0),
    .srtc_enable (srtc_enable)
  );

  always #5 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [26:0] ref_map(input logic [23:0] a, input logic [23:0] mcu,
                                          input logic ph, input mapper_t m,
                                          input logic [7:0] f, input logic [23:0] rmask,
                                          input logic [23:0] smask, input logic [14:0] bsx);
    logic [7:0]  bank;
    logic [15:0] off;
    logic [14:0] hoff;
    logic        hit;
    logic        sav;
    logic        psram;
    logic        cart;
    logic [23:0] addr;
    logic [23:0] base;
    bank = a[23:16];
    off  = a[15:0];
    hoff = off[14:0] - 15'h6000;
    if (f[1]) begin
      hit = (bank >= 8'hD0 && bank <= 8'hD7) && off < 16'h1000;
    end else if (m == LOROM) begin
      hit = (bank[6:0] >= 7'h70 && bank[6:0] <= 7'h7D) && off < 16'h8000;
    end else if (m == BSX) begin
      hit = (bank >= 8'h10 && bank <= 8'h17) && off[15:12] == 4'h5;
    end else if (m == MENU || m == HIROM || m == EXHIROM) begin
      hit = (bank[6:0] >= 7'h30 && bank[6:0] <= 7'h3F)
         && off >= 16'h6000 && off < 16'h8000;
    end else begin
      hit = 1'b0;
    end
    sav   = hit & smask[0];
    psram = (bsx[BSX_MIRROR_60] && bank[7:4] == 4'h6)
         || (!bsx[BSX_NO_MIRROR_40] && bank[7:4] == 4'h4)
         || (!bsx[BSX_NO_MIRROR_50] && bank[7:4] == 4'h5)
         || (bank >= 8'h70 && bank <= 8'h77)
         || (bank >= 8'h20 && bank <= 8'h3F && off >= 16'h6000 && off < 16'h8000);
    cart  = (bsx[BSX_CART_LO] && bank <= 8'h1F)
         || (bsx[BSX_CART_HI] && bank >= 8'h80 && bank <= 8'h9F);
    base  = bsx[BSX_PRAM_TO_ROM] ? 24'h400000 : 24'h0;
    if (f[1] && sav) begin
      addr = 24'hE00000 + ({9'd0, hoff} & smask);        // ST0010 uses HiROM save RAM math
    end else begin
      case (m)
        HIROM:   addr = sav ? 24'hE00000 + ({9'd0, hoff} & smask) : {1'b0, a[22:0]} & rmask;
        EXHIROM: addr = sav ? 24'hE00000 + ({9'd0, hoff} & smask)
                            : {1'b0, ~a[23], a[21:0]} & rmask;
        LOROM:   addr = sav ? 24'hE00000 + ({9'd0, off[14:0]} & smask)
                            : {2'b00, bank[6:0], off[14:0]} & rmask;
        MENU:    addr = sav ? 24'hFF0000 + ({9'd0, hoff} & smask)
                            : 24'hE00000 + ({1'b0, a[22:0]} & rmask);
        BSX: begin
          if (sav) addr = 24'hE00000 + {9'd0, bank[2:0], off[11:0]};
          else if (psram) addr = 24'h400000 + (a & 24'h07FFFF);
          else if (cart) addr = 24'h800000 + ({1'b0, bank, off[14:0]} & 24'h0FFFFF);
          else if (bsx[BSX_HIROM]) addr = base + ({2'b00, a[21:0]} & rmask);
          else addr = base + ({1'b0, bank, off[14:0]} & rmask);
        end
        default: addr = 24'h0;
      endcase
    end
    if (ph) addr = mcu;
    return {sav | (m == BSX && psram), sav, a[22] | a[15], addr};
  endfunction

  always_comb begin
    exp_map  = ref_map(snes_addr, mcu_addr, bus_phase, sh_mapper, sh_feat,
                       sh_rom, sh_sram, sh_bsx);
    exp_msu  = sh_feat[FEAT_MSU1] && !snes_addr[22] && snes_addr[15:0] >= 16'h2000
            && snes_addr[15:0] <= 16'h2007;
    exp_srtc = sh_feat[FEAT_SRTC] && !snes_addr[22]
            && (snes_addr[15:0] == 16'h2800 || snes_addr[15:0] == 16'h2801);
    exp_dspx = 1'b0;
    exp_a0   = 1'b1;
    if (sh_feat[FEAT_DSPX] && sh_mapper == LOROM) begin
      exp_a0   = snes_addr[14];
      exp_dspx = sh_rom[20] ? (snes_addr[22:20] == 3'b110 && !snes_addr[15])
                            : (snes_addr[22:20] == 3'b011 && snes_addr[15]);
    end else if (sh_feat[FEAT_DSPX] && sh_mapper == HIROM) begin
      exp_a0   = snes_addr[12];
      exp_dspx = snes_addr[22:20] == 3'b000 && snes_addr[15:13] == 3'b011;
    end else if (!sh_feat[FEAT_DSPX] && sh_feat[FEAT_ST0010]) begin
      exp_a0   = snes_addr[0];
      exp_dspx = snes_addr[22:16] == 7'h68 && !snes_addr[15];   // ST0010 port, 68:0000-7FFF
    end
  end

  task automatic fail_check(input string msg);
    fail_count = fail_count + 1;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopping on first mismatch");
  endtask

  task automatic fail_timeout(input string msg);
    $display("Timed out waiting for %s", msg);
    $display("Test failed");
    $fatal(1, "stopping on timeout");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks against the model
  ////////////////////////////////////////////////////////////////////////////

  a_map: assert property (@(posedge CLK) disable iff (!rst_n)
    {is_writable, is_saveram, is_rom, mem_addr} == exp_map)
    else fail_check($sformatf("map of %h gave %h/%b%b%b, expected %h", snes_addr, mem_addr,
                    is_writable, is_saveram, is_rom, exp_map));
  a_bsx: assert property (@(posedge CLK) disable iff (!rst_n) use_bsx == (sh_mapper == BSX))
    else fail_check("use_bsx wrong");
  a_srtc: assert property (@(posedge CLK) disable iff (!rst_n) srtc_enable == exp_srtc)
    else fail_check($sformatf("srtc_enable wrong at %h", snes_addr));
  a_a0: assert property (@(posedge CLK) disable iff (!rst_n) dspx_a0 == exp_a0)
    else fail_check($sformatf("dspx_a0 wrong at %h", snes_addr));
  // Enable needs four samples of the select, three to six edges old
  a_msu: assert property (@(posedge CLK) disable iff (!rst_n)
    msu_enable == ($past(exp_msu, 3) && $past(exp_msu, 4) && $past(exp_msu, 5)
                   && $past(exp_msu, 6)))
    else fail_check("msu_enable does not follow the filtered select");
  a_dspx: assert property (@(posedge CLK) disable iff (!rst_n)
    dspx_enable == ($past(exp_dspx, 3) && $past(exp_dspx, 4) && $past(exp_dspx, 5)
                    && $past(exp_dspx, 6)))
    else fail_check("dspx_enable does not follow the filtered select");

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic cfg_write(input cfg_reg_t sel, input logic [23:0] data);
    @(negedge CLK);
    cfg_we   = 1'b1;
    cfg_sel  = sel;
    cfg_data = data;
    @(posedge CLK);
    case (sel)
      CFG_MAPPER:       sh_mapper = mapper_t'(data[2:0]);
      CFG_FEATURES:     sh_feat   = data[7:0];
      CFG_ROM_MASK:     sh_rom    = data;
      CFG_SAVERAM_MASK: sh_sram   = data;
      default:          sh_bsx    = data[14:0];
    endcase
    @(negedge CLK);
    cfg_we = 1'b0;
  endtask

  // Random addresses, some pushed into the save RAM windows
  task automatic drive_random(input integer n, input logic mcu);
    logic [31:0] r;
    logic [23:0] a;
    for (int i = 0; i < n; i++) begin
      @(negedge CLK);
      r = $random(seed);
      a = r[23:0];
      case (r[31:29])
        3'd0: begin
          a[22:20] = 3'b011;
          a[15:13] = 3'b011;
        end
        3'd1: begin
          a[22:20] = 3'b111;
          a[15]    = 1'b0;
        end
        3'd2: begin
          a[23:19] = 5'b00010;
          a[15:12] = 4'h5;
        end
        3'd3: begin
          a[23:19] = 5'b11010;
          a[15:12] = 4'h0;
        end
        default: ;
      endcase
      snes_addr = a;
      r = $random(seed);
      mcu_addr  = r[23:0];
      bus_phase = mcu;
    end
  endtask

  // Rise after 6 edges, fall after 3, single-cycle glitch ignored
  task automatic check_filter(input logic [23:0] win, input logic [23:0] away, input logic dsp);
    integer cnt;
    @(negedge CLK);
    snes_addr = away;
    repeat (8) @(negedge CLK);
    snes_addr = win;
    cnt = 0;
    while ((dsp ? dspx_enable : msu_enable) == 1'b0) begin
      @(posedge CLK);
      cnt = cnt + 1;
      @(negedge CLK);
      if (cnt > 20) fail_timeout("enable to rise");
    end
    assert (cnt == 6) else fail_check($sformatf("enable rose after %0d edges", cnt));
    snes_addr = away;
    cnt = 0;
    while ((dsp ? dspx_enable : msu_enable) == 1'b1) begin
      @(posedge CLK);
      cnt = cnt + 1;
      @(negedge CLK);
      if (cnt > 20) fail_timeout("enable to fall");
    end
    assert (cnt == 3) else fail_check($sformatf("enable fell after %0d edges", cnt));
    repeat (6) @(negedge CLK);
    snes_addr = win;
    @(negedge CLK);
    snes_addr = away;
    for (int i = 0; i < 10; i++) begin
      @(negedge CLK);
      assert (!(dsp ? dspx_enable : msu_enable)) else fail_check("glitch raised enable");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    rst_n = 1'b0;
    cfg_we = 1'b0;
    cfg_sel = CFG_MAPPER;
    cfg_data = 24'h0;
    snes_addr = 24'h008000;
    mcu_addr = 24'h0;
    bus_phase = 1'b0;
    sh_mapper = MENU;
    sh_feat = 8'h00;
    sh_rom = 24'hFFFFFF;
    sh_sram = 24'h0;
    sh_bsx = 15'h0;
    seed = 74582;
    fail_count = 0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    @(negedge CLK);
    assert (!msu_enable && !dspx_enable && !is_saveram) else fail_check("state after reset");
    assert (mem_addr == 24'hE08000) else fail_check("menu ROM address after reset");

    cfg_write(CFG_MAPPER, 24'd0);                    // HiROM
    cfg_write(CFG_ROM_MASK, 24'h3FFFFF);
    cfg_write(CFG_SAVERAM_MASK, 24'h001FFF);
    drive_random(200, 1'b0);
    cfg_write(CFG_MAPPER, 24'd1);                    // LoROM
    cfg_write(CFG_ROM_MASK, 24'h1FFFFF);
    cfg_write(CFG_SAVERAM_MASK, 24'h0007FF);
    drive_random(200, 1'b0);
    cfg_write(CFG_MAPPER, 24'd2);                    // ExHiROM
    cfg_write(CFG_ROM_MASK, 24'h7FFFFF);
    cfg_write(CFG_SAVERAM_MASK, 24'h007FFF);
    drive_random(200, 1'b0);
    cfg_write(CFG_MAPPER, 24'd7);
    cfg_write(CFG_SAVERAM_MASK, 24'h000FFE);         // Save RAM off through bit 0
    drive_random(200, 1'b0);
    cfg_write(CFG_SAVERAM_MASK, 24'h00FFFF);
    drive_random(200, 1'b0);

    // BS-X with several control words
    cfg_write(CFG_MAPPER, 24'd3);
    cfg_write(CFG_BSX_REGS, 24'h000000);
    drive_random(200, 1'b0);
    cfg_write(CFG_BSX_REGS, 24'h000068);
    drive_random(200, 1'b0);
    cfg_write(CFG_BSX_REGS, 24'h000186);
    drive_random(200, 1'b0);
    cfg_write(CFG_BSX_REGS, 24'h0001FE);
    drive_random(200, 1'b0);

    drive_random(100, 1'b1);                         // MCU phase under BS-X
    cfg_write(CFG_MAPPER, 24'd1);
    drive_random(100, 1'b1);
    @(negedge CLK);
    bus_phase = 1'b0;

    cfg_write(CFG_FEATURES, 24'h000008);             // MSU1
    check_filter(24'h002003, 24'h002010, 1'b0);
    cfg_write(CFG_FEATURES, 24'h000001);             // DSPx on LoROM, both mask sizes
    cfg_write(CFG_ROM_MASK, 24'h1FFFFF);
    check_filter(24'h604000, 24'h000000, 1'b1);
    cfg_write(CFG_ROM_MASK, 24'h0FFFFF);
    check_filter(24'h308000, 24'h000000, 1'b1);
    cfg_write(CFG_FEATURES, 24'h000002);             // ST0010
    check_filter(24'h680001, 24'h000000, 1'b1);

    cfg_write(CFG_FEATURES, 24'h000004);             // S-RTC sweep around 2800
    for (int k = 0; k < 12; k++) begin
      @(negedge CLK);
      snes_addr = {(k >= 6) ? 8'h40 : 8'h00, 16'h27FE + 16'(k % 6)};
    end
    cfg_write(CFG_FEATURES, 24'h000000);
    @(negedge CLK);
    snes_addr = 24'h002800;
    repeat (3) @(negedge CLK);

    if (fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "checks failed");
    end
  end

  initial begin
    for (int t = 0; t < 200000; t++) begin
      #10;
    end
    fail_timeout("end of simulation");
  end

endmodule

// File: verilog/address_map.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module address_map (
  input  logic [`CART_ADDR_W-1:0] snes_addr,
  input  logic [`CART_ADDR_W-1:0] mcu_addr,
  input  logic                    bus_phase,     // 1 = MCU owns the bus
  input  cart_pkg::mapper_t       mapper,
  input  logic [`CART_ADDR_W-1:0] rom_mask,
  input  logic [`CART_ADDR_W-1:0] saveram_mask,
  input  logic [`CART_BSX_W-1:0]  bsx_regs,
  input  logic                    st0010_mode,
  output logic [`CART_ADDR_W-1:0] mem_addr,
  output logic                    is_rom,
  output logic                    is_saveram,
  output logic                    is_writable
);
  import cart_pkg::*;

  // Region hits
  logic hi_sram_hit;
  logic lo_sram_hit;
  logic bsx_sram_hit;
  logic st_sram_hit;
  logic sram_hit;
  logic bsx_psram_hit;
  logic bsx_cart_hit;

  // Candidate memory addresses
  logic [14:0]             hi_sram_off;
  logic [`CART_ADDR_W-1:0] hi_sram_addr;
  logic [`CART_ADDR_W-1:0] lo_sram_addr;
  logic [`CART_ADDR_W-1:0] bsx_sram_addr;
  logic [`CART_ADDR_W-1:0] menu_sram_addr;
  logic [`CART_ADDR_W-1:0] hirom_addr;
  logic [`CART_ADDR_W-1:0] lorom_addr;
  logic [`CART_ADDR_W-1:0] exhirom_addr;
  logic [`CART_ADDR_W-1:0] menu_rom_addr;
  logic [`CART_ADDR_W-1:0] bsx_psram_addr;
  logic [`CART_ADDR_W-1:0] bsx_cart_addr;
  logic [`CART_ADDR_W-1:0] bsx_base;
  logic [`CART_ADDR_W-1:0] bsx_rom_addr;
  logic [`CART_ADDR_W-1:0] console_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Region classification
  ////////////////////////////////////////////////////////////////////////////

  // HiROM style: 30-3F / B0-BF, 6000-7FFF
  assign hi_sram_hit = ~snes_addr[22] & (&snes_addr[21:20])
                     & ~snes_addr[15] & (&snes_addr[14:13]);

  // LoROM: 70-7D / F0-FD, 0000-7FFF
  assign lo_sram_hit = (&snes_addr[22:20]) & (snes_addr[19:16] < 4'hE)
                     & ~snes_addr[15];

  // BS-X: 10-17, 5000-5FFF
  assign bsx_sram_hit = (snes_addr[23:19] == 5'b00010)
                      & (snes_addr[15:12] == 4'h5);

  // ST0010 battery RAM: D0-D7, 0000-0FFF
  assign st_sram_hit = (snes_addr[23:19] == 5'b11010)
                     & (snes_addr[15:12] == 4'h0);

  always_comb begin
    if (st0010_mode) begin
      sram_hit = st_sram_hit;
    end else begin
      case (mapper)
        HIROM, EXHIROM, MENU: sram_hit = hi_sram_hit;
        LOROM:                sram_hit = lo_sram_hit;
        BSX:                  sram_hit = bsx_sram_hit;
        default:              sram_hit = 1'b0;
      endcase
    end
  end

  assign is_saveram = saveram_mask[0] & sram_hit;   // Mask bit 0 doubles as enable

  // Upper half of every bank, and everything in 40-7D / C0-FF
  assign is_rom = snes_addr[22] | snes_addr[15];

  // PSRAM windows writable under BS-X
  assign bsx_psram_hit =
      (bsx_regs[BSX_MIRROR_60] & (snes_addr[23:20] == 4'h6))
    | (~bsx_regs[BSX_NO_MIRROR_40] & (snes_addr[23:20] == 4'h4))
    | (~bsx_regs[BSX_NO_MIRROR_50] & (snes_addr[23:20] == 4'h5))
    | (snes_addr[23:19] == 5'b01110)                            // 70-77
    | ((snes_addr[23:21] == 3'b001) & (snes_addr[15:13] == 3'b011));

  assign is_writable = is_saveram | ((mapper == BSX) & bsx_psram_hit);

  assign bsx_cart_hit = (bsx_regs[BSX_CART_LO] & (snes_addr[23:21] == 3'b000))
                      | (bsx_regs[BSX_CART_HI] & (snes_addr[23:21] == 3'b100));

  ////////////////////////////////////////////////////////////////////////////
  // Address translation
  ////////////////////////////////////////////////////////////////////////////

  assign hi_sram_off    = snes_addr[14:0] - `HIROM_SRAM_OFFSET;  // Wraps mod 32K
  assign hi_sram_addr   = `SAVERAM_BASE + ({9'd0, hi_sram_off} & saveram_mask);
  assign lo_sram_addr   = `SAVERAM_BASE + ({9'd0, snes_addr[14:0]} & saveram_mask);
  assign menu_sram_addr = `MENU_SAVERAM_BASE + ({9'd0, hi_sram_off} & saveram_mask);
  assign bsx_sram_addr  = `SAVERAM_BASE
                        + {9'd0, snes_addr[18:16], snes_addr[11:0]};

  assign hirom_addr    = {1'b0, snes_addr[22:0]} & rom_mask;
  assign lorom_addr    = {2'b00, snes_addr[22:16], snes_addr[14:0]} & rom_mask;
  assign exhirom_addr  = {1'b0, ~snes_addr[23], snes_addr[21:0]} & rom_mask;
  assign menu_rom_addr = `MENU_ROM_BASE + hirom_addr;

  // BS-X regions
  assign bsx_psram_addr = `BSX_PSRAM_BASE + (snes_addr & `BSX_PSRAM_MASK);
  assign bsx_cart_addr  = `BSX_CART_BASE
                        + ({1'b0, snes_addr[23:16], snes_addr[14:0]} & `BSX_CART_MASK);
  assign bsx_base       = bsx_regs[BSX_PRAM_TO_ROM] ? `BSX_PSRAM_BASE : '0;
  assign bsx_rom_addr   = bsx_base
                        + (bsx_regs[BSX_HIROM]
                           ? ({2'b00, snes_addr[21:0]} & rom_mask)
                           : ({1'b0, snes_addr[23:16], snes_addr[14:0]} & rom_mask));

  always_comb begin
    if (st0010_mode && is_saveram) begin
      console_addr = hi_sram_addr;
    end else begin
      case (mapper)
        HIROM:   console_addr = is_saveram ? hi_sram_addr : hirom_addr;
        LOROM:   console_addr = is_saveram ? lo_sram_addr : lorom_addr;
        EXHIROM: console_addr = is_saveram ? hi_sram_addr : exhirom_addr;
        BSX: begin
          if (is_saveram) begin
            console_addr = bsx_sram_addr;
          end else if (bsx_psram_hit) begin
            console_addr = bsx_psram_addr;
          end else if (bsx_cart_hit) begin
            console_addr = bsx_cart_addr;
          end else begin
            console_addr = bsx_rom_addr;
          end
        end
        MENU:    console_addr = is_saveram ? menu_sram_addr : menu_rom_addr;
        default: console_addr = '0;
      endcase
    end
  end

  // MCU phase bypasses the whole map
  assign mem_addr = bus_phase ? mcu_addr : console_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Save RAM is always a write target, whatever the mapper does with PSRAM
  always_comb begin
    a_saveram_writable: assert (!is_saveram || is_writable)
      else $error("save RAM address not flagged writable");
  end

endmodule

// File: verilog/cart_decoder_top.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module cart_decoder_top (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    cfg_we,
  input  cart_pkg::cfg_reg_t      cfg_sel,
  input  logic [`CART_ADDR_W-1:0] cfg_data,
  input  logic [`CART_ADDR_W-1:0] snes_addr,
  input  logic [`CART_ADDR_W-1:0] mcu_addr,
  input  logic                    bus_phase,
  output logic [`CART_ADDR_W-1:0] mem_addr,
  output logic                    is_rom,
  output logic                    is_saveram,
  output logic                    is_writable,
  output logic                    use_bsx,
  output logic                    msu_enable,
  output logic                    dspx_enable,
  output logic                    dspx_a0,
  output logic                    srtc_enable
);
  import cart_pkg::*;

  mapper_t                 mapper;
  logic [`CART_FEAT_W-1:0] features;
  logic [`CART_ADDR_W-1:0] rom_mask;
  logic [`CART_ADDR_W-1:0] saveram_mask;
  logic [`CART_BSX_W-1:0]  bsx_regs;

  logic msu_raw;
  logic dspx_raw;
  logic lorom_dsp_hit;
  logic hirom_dsp_hit;
  logic st0010_hit;

  mapper_config u_config (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .cfg_we       (cfg_we),
    .cfg_sel      (cfg_sel),
    .cfg_data     (cfg_data),
    .mapper       (mapper),
    .features     (features),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .bsx_regs     (bsx_regs)
  );

  address_map u_map (
    .snes_addr    (snes_addr),
    .mcu_addr     (mcu_addr),
    .bus_phase    (bus_phase),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .bsx_regs     (bsx_regs),
    .st0010_mode  (features[FEAT_ST0010]),
    .mem_addr     (mem_addr),
    .is_rom       (is_rom),
    .is_saveram   (is_saveram),
    .is_writable  (is_writable)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Peripheral decode
  ////////////////////////////////////////////////////////////////////////////

  assign use_bsx = (mapper == BSX);

  // MSU1 registers at 2000-2007 in system banks
  assign msu_raw = features[FEAT_MSU1] & ~snes_addr[22]
                 & ((snes_addr[15:0] & 16'hFFF8) == 16'h2000);

  assign srtc_enable = features[FEAT_SRTC] & ~snes_addr[22]
                     & ((snes_addr[15:0] & 16'hFFFE) == 16'h2800);

  // LoROM DSP sits at 60-6F:0000-7FFF on big carts, else 30-3F:8000-FFFF
  assign lorom_dsp_hit = rom_mask[20]
    ? (snes_addr[22] & snes_addr[21] & ~snes_addr[20] & ~snes_addr[15])
    : (~snes_addr[22] & snes_addr[21] & snes_addr[20] & snes_addr[15]);
  assign hirom_dsp_hit = ~snes_addr[22] & ~snes_addr[21] & ~snes_addr[20]
                       & ~snes_addr[15] & (&snes_addr[14:13]);     // 00-0F:6000-7FFF
  assign st0010_hit = snes_addr[22] & snes_addr[21] & ~snes_addr[20]
                    & (snes_addr[19:16] == 4'h8) & ~snes_addr[15];  // 68:0000-7FFF

  assign dspx_raw = features[FEAT_DSPX]
    ? (((mapper == LOROM) & lorom_dsp_hit) | ((mapper == HIROM) & hirom_dsp_hit))
    : (features[FEAT_ST0010] & st0010_hit);

  // Data/status register select
  always_comb begin
    if (features[FEAT_DSPX] && mapper == LOROM) begin
      dspx_a0 = snes_addr[14];
    end else if (features[FEAT_DSPX] && mapper == HIROM) begin
      dspx_a0 = snes_addr[12];
    end else if (!features[FEAT_DSPX] && features[FEAT_ST0010]) begin
      dspx_a0 = snes_addr[0];
    end else begin
      dspx_a0 = 1'b1;
    end
  end

  select_filter msu_filter (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .raw_select (msu_raw),
    .enable     (msu_enable)
  );

  select_filter dspx_filter (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .raw_select (dspx_raw),
    .enable     (dspx_enable)
  );

endmodule

// File: verilog/cart_params.svh
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////

`define CART_ADDR_W        24          // Console bus and memory address
`define CART_BSX_W         15          // BS-X control word
`define CART_FEAT_W        8           // Feature enable word

////////////////////////////////////////////////////////////////////////////
// External memory regions
////////////////////////////////////////////////////////////////////////////

`define SAVERAM_BASE       24'hE00000
`define MENU_SAVERAM_BASE  24'hFF0000
`define MENU_ROM_BASE      24'hE00000
`define BSX_PSRAM_BASE     24'h400000
`define BSX_CART_BASE      24'h800000
`define BSX_PSRAM_MASK     24'h07FFFF  // 512 KiB PSRAM
`define BSX_CART_MASK      24'h0FFFFF  // 1 MiB cartridge window
`define HIROM_SRAM_OFFSET  15'h6000    // Save RAM window start in the bank

// Select filter shift register
`define SELECT_DEPTH       8
`define SELECT_TAP_LO      2
`define SELECT_TAP_HI      5

`endif

// File: verilog/cart_pkg.sv
package cart_pkg;

  // Mapper code as detected by the MCU
  typedef enum logic [2:0] {
    HIROM   = 3'd0,
    LOROM   = 3'd1,
    EXHIROM = 3'd2,
    BSX     = 3'd3,
    MENU    = 3'd7
  } mapper_t;

  // Bit positions in the feature word
  typedef enum logic [2:0] {
    FEAT_DSPX   = 3'd0,
    FEAT_ST0010 = 3'd1,
    FEAT_SRTC   = 3'd2,
    FEAT_MSU1   = 3'd3
  } feature_t;

  // Target of an MCU config write
  typedef enum logic [2:0] {
    CFG_MAPPER       = 3'd0,
    CFG_FEATURES     = 3'd1,
    CFG_ROM_MASK     = 3'd2,
    CFG_SAVERAM_MASK = 3'd3,
    CFG_BSX_REGS     = 3'd4
  } cfg_reg_t;

  // BS-X control bits
  localparam int BSX_PRAM_TO_ROM  = 1;  // PSRAM instead of flash in ROM area
  localparam int BSX_HIROM        = 2;
  localparam int BSX_MIRROR_60    = 3;
  localparam int BSX_NO_MIRROR_40 = 5;
  localparam int BSX_NO_MIRROR_50 = 6;
  localparam int BSX_CART_LO      = 7;  // Cartridge ROM at 00-1F:8000-FFFF
  localparam int BSX_CART_HI      = 8;  // Cartridge ROM at 80-9F:8000-FFFF

endpackage

// File: verilog/mapper_config.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module mapper_config (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    cfg_we,        // Write strobe from the MCU
  input  cart_pkg::cfg_reg_t      cfg_sel,
  input  logic [`CART_ADDR_W-1:0] cfg_data,
  output cart_pkg::mapper_t       mapper,
  output logic [`CART_FEAT_W-1:0] features,
  output logic [`CART_ADDR_W-1:0] rom_mask,
  output logic [`CART_ADDR_W-1:0] saveram_mask,
  output logic [`CART_BSX_W-1:0]  bsx_regs
);
  import cart_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  // Boot into the menu until the MCU has looked at the cartridge header
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mapper       <= MENU;
      features     <= '0;
      rom_mask     <= '1;
      saveram_mask <= '0;            // Save RAM off
      bsx_regs     <= '0;
    end else if (cfg_we) begin
      case (cfg_sel)
        CFG_MAPPER: begin
          mapper <= mapper_t'(cfg_data[2:0]);
        end
        CFG_FEATURES: begin
          features <= cfg_data[`CART_FEAT_W-1:0];
        end
        CFG_ROM_MASK: begin
          rom_mask <= cfg_data;
        end
        CFG_SAVERAM_MASK: begin
          saveram_mask <= cfg_data;
        end
        CFG_BSX_REGS: begin
          bsx_regs <= cfg_data[`CART_BSX_W-1:0];
        end
        default: begin
          // Unused select codes leave everything as is
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Downstream decode is purely combinational, X here spreads everywhere
  a_cfg_known: assert property (
    @(posedge CLK) disable iff (!rst_n)
    !$isunknown({mapper, features, rom_mask, saveram_mask, bsx_regs})
  ) else $error("config register went unknown");

endmodule

// File: verilog/select_filter.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module select_filter (
  input  logic CLK,
  input  logic rst_n,
  input  logic raw_select,   // Decoded condition, may glitch
  output logic enable
);

  logic [`SELECT_DEPTH-1:0] history;

  // One sample per clock, newest in bit 0
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      history <= '0;
    end else begin
      history <= {history[`SELECT_DEPTH-2:0], raw_select};
    end
  end

  // Bus must have held the window for four samples, skipping the two newest
  assign enable = &history[`SELECT_TAP_HI:`SELECT_TAP_LO];

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // The newest tap in the window is three samples old
  a_enable_history: assert property (
    @(posedge CLK) disable iff (!rst_n)
    enable |-> $past(raw_select, 3)
  ) else $error("enable without earlier select");

endmodule
